/* all.f */
+incdir+tests
common/soc_map_pkg.sv
common/periph_pkg.sv
design/soc_bus.sv
design/dmem.sv
design/clint.sv
uart/uart_regs.sv
design/plic.sv
design/rv_periph_soc.sv
tests/tb_rv_periph_soc.sv

/* common/periph_pkg.sv */
// Peripheral register map
// CLINT, UART and PLIC offsets, bit positions, interrupt source numbers
`default_nettype none

package periph_pkg;

  // ========================================
  // CLINT
  // ========================================
  localparam logic [23:0] clint_msip        = 24'h00_0000;
  localparam logic [23:0] clint_mtimecmp_lo = 24'h00_4000;
  localparam logic [23:0] clint_mtimecmp_hi = 24'h00_4004;
  localparam logic [23:0] clint_mtime_lo    = 24'h00_BFF8;
  localparam logic [23:0] clint_mtime_hi    = 24'h00_BFFC;

  // ========================================
  // UART
  // ========================================
  localparam logic [23:0] uart_rbr_thr = 24'h00_0000;
  localparam logic [23:0] uart_ier     = 24'h00_0004;
  localparam logic [23:0] uart_lsr     = 24'h00_0014;

  // Line status and interrupt enable bits
  localparam int lsr_dr   = 0;
  localparam int lsr_thre = 5;
  localparam int ier_rx   = 0;
  localparam int ier_tx   = 1;

  // ========================================
  // PLIC
  // ========================================
  // Source 0 is reserved and never pends
  localparam int plic_sources = 4;
  localparam int plic_id_w    = 2;
  localparam int irq_src_uart = 1;
  localparam int irq_src_ext0 = 2;
  localparam int irq_src_ext1 = 3;

  localparam logic [23:0] plic_pending = 24'h00_1000;
  localparam logic [23:0] plic_enable  = 24'h00_2000;
  localparam logic [23:0] plic_claim   = 24'h20_0004;

endpackage

`default_nettype wire

/* common/soc_map_pkg.sv */
// Address map of the platform
// Bus widths, region codes and data memory geometry
// Bus address union with a decoder view and a memory view
`default_nettype none

package soc_map_pkg;

  // ========================================
  // Bus widths
  // ========================================
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int sel_w  = 4;

  // ========================================
  // Region codes, address bits 31..24
  // ========================================
  localparam logic [7:0] region_clint = 8'h02;
  localparam logic [7:0] region_plic  = 8'h0C;
  localparam logic [7:0] region_uart  = 8'h10;
  localparam logic [7:0] region_dmem  = 8'h80;

  // Data memory, 4 KB as 32-bit words
  localparam int dmem_words   = 1024;
  localparam int dmem_index_w = 10;

  // One bus address, two readings
  // Decoder looks at region and offset
  // Memory looks at word index and byte lane
  typedef union packed {
    struct packed {
      logic [7:0]  region;
      logic [23:0] offset;
    } dec;
    struct packed {
      logic [addr_w-dmem_index_w-3:0] upper;
      logic [dmem_index_w-1:0]        index;
      logic [1:0]                     lane;
    } mem;
  } soc_addr_u;

endpackage

`default_nettype wire

/* design/clint.sv */
// Core-local interruptor
// 64-bit mtime and mtimecmp, msip bit
// Registered timer interrupt
`default_nettype none

module clint (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [23:0] offset,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        msip,
  output logic        mtip
);
  import periph_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        access;

  assign access = stb & ~ack;

  // Register writes
  always_ff @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      msip     <= 1'b0;
      mtimecmp <= '1;
    end else begin
      ack <= access;
      if (access && we) begin
        case (offset)
          clint_msip:        msip            <= dat_w[0];
          clint_mtimecmp_lo: mtimecmp[31:0]  <= dat_w;
          clint_mtimecmp_hi: mtimecmp[63:32] <= dat_w;
          default: ;
        endcase
      end
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (access && !we) begin
      case (offset)
        clint_msip:        dat_r <= {31'b0, msip};
        clint_mtimecmp_lo: dat_r <= mtimecmp[31:0];
        clint_mtimecmp_hi: dat_r <= mtimecmp[63:32];
        clint_mtime_lo:    dat_r <= mtime[31:0];
        clint_mtime_hi:    dat_r <= mtime[63:32];
        default:           dat_r <= '0;
      endcase
    end
  end

  // Free-running timer, compare one cycle late
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
      mtip  <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      mtip  <= (mtime >= mtimecmp);
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    ack |=> !ack);

endmodule

`default_nettype wire

/* design/dmem.sv */
// Data memory, 4 KB word array
// Byte-lane writes, whole-word reads, one-cycle ack
`default_nettype none

module dmem (
  input  logic                           clk,
  input  logic                           stb,
  input  logic                           we,
  input  soc_map_pkg::soc_addr_u         adr,
  input  logic [soc_map_pkg::sel_w-1:0]  sel,
  input  logic [soc_map_pkg::data_w-1:0] dat_w,
  output logic [soc_map_pkg::data_w-1:0] dat_r,
  output logic                           ack
);
  import soc_map_pkg::*;

  logic [data_w-1:0] mem [dmem_words];
  logic              access;

  // First cycle of a strobe only
  assign access = stb & ~ack;

  // Lane merge on writes
  always_ff @(posedge clk) begin
    if (access && we) begin
      for (int lane = 0; lane < sel_w; lane++) begin
        if (sel[lane]) begin
          mem[adr.mem.index][8*lane +: 8] <= dat_w[8*lane +: 8];
        end
      end
    end
  end

  // Read word and ack land on the same edge
  always_ff @(posedge clk) begin
    if (access) begin
      dat_r <= mem[adr.mem.index];
    end
    ack <= access;
  end

endmodule

`default_nettype wire

/* design/plic.sv */
// Platform interrupt controller
// Level gateway, pending and enable bits
// Claim/complete with lowest ID first
`default_nettype none

module plic (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [23:0] offset,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  input  logic [3:0]  sources,
  output logic        meip
);
  import periph_pkg::*;

  logic [plic_sources-1:0] pending;
  logic [plic_sources-1:0] pending_next;
  logic [plic_sources-1:0] enable;
  logic [plic_sources-1:0] in_service;
  logic [plic_id_w-1:0]    claim_id;
  logic                    access;
  logic                    claim_read;
  logic                    complete_write;
  logic                    enable_write;

  assign access         = stb & ~ack;
  assign claim_read     = access & ~we & (offset == plic_claim);
  assign complete_write = access & we & (offset == plic_claim);
  assign enable_write   = access & we & (offset == plic_enable);

  // Lowest enabled pending source, 0 if none
  always_comb begin
    claim_id = '0;
    for (int i = plic_sources - 1; i > 0; i--) begin
      if (pending[i] && enable[i]) begin
        claim_id = plic_id_w'(i);
      end
    end
  end

  // Gateway, then the claim clears its bit
  always_comb begin
    pending_next    = pending | (sources & ~in_service);
    pending_next[0] = 1'b0;
    if (claim_read) begin
      pending_next[claim_id] = 1'b0;
    end
  end

  assign meip = |(pending & enable);

  always_ff @(posedge clk) begin
    if (rst) begin
      ack        <= 1'b0;
      pending    <= '0;
      enable     <= '0;
      in_service <= '0;
    end else begin
      ack     <= access;
      pending <= pending_next;
      if (enable_write) begin
        enable <= {dat_w[plic_sources-1:1], 1'b0};
      end
      if (claim_read && claim_id != '0) begin
        in_service[claim_id] <= 1'b1;
      end
      if (complete_write) begin
        in_service[dat_w[plic_id_w-1:0]] <= 1'b0;
      end
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (access && !we) begin
      case (offset)
        plic_pending: dat_r <= 32'(pending);
        plic_enable:  dat_r <= 32'(enable);
        plic_claim:   dat_r <= 32'(claim_id);
        default:      dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/rv_periph_soc.sv */
// Top level of the peripheral platform
// Bus controller with data memory, CLINT, UART and PLIC
`default_nettype none

module rv_periph_soc (
  input  logic                           clk,
  input  logic                           rst,
  // Wishbone slave port for the CPU data side
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [soc_map_pkg::addr_w-1:0] adr,
  input  logic [soc_map_pkg::data_w-1:0] dat_w,
  input  logic [soc_map_pkg::sel_w-1:0]  sel,
  output logic [soc_map_pkg::data_w-1:0] dat_r,
  output logic                           ack,
  output logic                           err,
  // UART serial side
  output logic                           tx_valid,
  output logic [7:0]                     tx_data,
  input  logic                           tx_ready,
  input  logic                           rx_valid,
  input  logic [7:0]                     rx_data,
  output logic                           rx_ready,
  // Interrupts
  input  logic [1:0]                     ext_irq,
  output logic                           msip,
  output logic                           mtip,
  output logic                           meip
);
  import periph_pkg::*;

  logic        clint_stb;
  logic        plic_stb;
  logic        uart_stb;
  logic        dmem_stb;
  logic [23:0] offset;
  logic        clint_ack;
  logic        plic_ack;
  logic        uart_ack;
  logic        dmem_ack;
  logic [31:0] clint_dat;
  logic [31:0] plic_dat;
  logic [31:0] uart_dat;
  logic [31:0] dmem_dat;
  logic        uart_irq;

  logic [plic_sources-1:0] plic_src;

  // Source 0 is tied off
  assign plic_src[0]            = 1'b0;
  assign plic_src[irq_src_uart] = uart_irq;
  assign plic_src[irq_src_ext0] = ext_irq[0];
  assign plic_src[irq_src_ext1] = ext_irq[1];

  soc_bus soc_bus_inst (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
    .ack(ack), .err(err), .dat_r(dat_r),
    .clint_stb(clint_stb), .plic_stb(plic_stb), .uart_stb(uart_stb), .dmem_stb(dmem_stb),
    .offset(offset),
    .clint_ack(clint_ack), .plic_ack(plic_ack), .uart_ack(uart_ack), .dmem_ack(dmem_ack),
    .clint_dat(clint_dat), .plic_dat(plic_dat), .uart_dat(uart_dat), .dmem_dat(dmem_dat)
  );

  dmem dmem_inst (
    .clk(clk), .stb(dmem_stb), .we(we), .adr(adr), .sel(sel),
    .dat_w(dat_w), .dat_r(dmem_dat), .ack(dmem_ack)
  );

  clint clint_inst (
    .clk(clk), .rst(rst), .stb(clint_stb), .we(we), .offset(offset),
    .dat_w(dat_w), .dat_r(clint_dat), .ack(clint_ack), .msip(msip), .mtip(mtip)
  );

  uart_regs uart_regs_inst (
    .clk(clk), .rst(rst), .stb(uart_stb), .we(we), .offset(offset),
    .dat_w(dat_w), .dat_r(uart_dat), .ack(uart_ack),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
    .irq(uart_irq)
  );

  plic plic_inst (
    .clk(clk), .rst(rst), .stb(plic_stb), .we(we), .offset(offset),
    .dat_w(dat_w), .dat_r(plic_dat), .ack(plic_ack),
    .sources(plic_src), .meip(meip)
  );

endmodule

`default_nettype wire

/* design/soc_bus.sv */
// Wishbone bus controller
// Region decode, strobe steering, response merge
// Error pulse for unmapped regions
`default_nettype none

module soc_bus (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [soc_map_pkg::addr_w-1:0] adr,
  input  logic [soc_map_pkg::sel_w-1:0]  sel,
  output logic                           ack,
  output logic                           err,
  output logic [soc_map_pkg::data_w-1:0] dat_r,
  output logic                           clint_stb,
  output logic                           plic_stb,
  output logic                           uart_stb,
  output logic                           dmem_stb,
  output logic [23:0]                    offset,
  input  logic                           clint_ack,
  input  logic                           plic_ack,
  input  logic                           uart_ack,
  input  logic                           dmem_ack,
  input  logic [soc_map_pkg::data_w-1:0] clint_dat,
  input  logic [soc_map_pkg::data_w-1:0] plic_dat,
  input  logic [soc_map_pkg::data_w-1:0] uart_dat,
  input  logic [soc_map_pkg::data_w-1:0] dmem_dat
);
  import soc_map_pkg::*;

  soc_addr_u bus_adr;
  logic      req;
  logic      unmapped;

  assign bus_adr = adr;
  assign req     = cyc & stb;
  assign offset  = bus_adr.dec.offset;

  // Steer the strobe by region, no delay
  // One compare per region, overlapping codes would raise two strobes
  always_comb begin
    clint_stb = req & (bus_adr.dec.region == region_clint);
    plic_stb  = req & (bus_adr.dec.region == region_plic);
    uart_stb  = req & (bus_adr.dec.region == region_uart);
    dmem_stb  = req & (bus_adr.dec.region == region_dmem);
    unmapped  = req & ~(clint_stb | plic_stb | uart_stb | dmem_stb);
  end

  // Only the addressed target may answer
  assign ack = (clint_ack & clint_stb) | (plic_ack & plic_stb) |
               (uart_ack & uart_stb) | (dmem_ack & dmem_stb);

  // Read data from the addressed target
  always_comb begin
    case (bus_adr.dec.region)
      region_clint: dat_r = clint_dat;
      region_plic:  dat_r = plic_dat;
      region_uart:  dat_r = uart_dat;
      region_dmem:  dat_r = dmem_dat;
      default:      dat_r = '0;
    endcase
  end

  // Unmapped access gets a one-cycle error pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      err <= 1'b0;
    end else begin
      err <= unmapped & ~err;
    end
  end

  // ========================================
  // Checks
  // ========================================
  a_one_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({clint_stb, plic_stb, uart_stb, dmem_stb}));

  a_ack_xor_err: assert property (@(posedge clk) disable iff (rst)
    !(ack && err));

  // Master holds the request until it sees a response
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    (req && !ack && !err) |=> (req && $stable({we, sel, adr})));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_periph_soc -f all.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Test passed"
  exit 0
fi
echo "Test failed"
exit 1

/* tests/tb_model.svh */
// Reference model for the platform testbench
// Data memory lane merge, PLIC claim rule, UART line status
// Typed compare tasks that stop the run at the first mismatch
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH
`default_nettype none

// ========================================
// Reference functions
// ========================================

// Word after a write, only the selected byte lanes change
function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0]  lanes);
  logic [31:0] merged;
  merged = old_word;
  for (int b = 0; b < 4; b++) begin
    if (lanes[b]) begin
      merged[8*b +: 8] = new_word[8*b +: 8];
    end
  end
  return merged;
endfunction

// Lowest source ID that is both pending and enabled
// Source 0 never counts, and 0 means nothing to claim
function automatic logic [31:0] ref_claim(input logic [3:0] pend,
                                          input logic [3:0] en);
  logic [31:0] id;
  id = 32'd0;
  for (int i = 1; i < periph_pkg::plic_sources; i++) begin
    if (pend[i] && en[i] && id == 32'd0) begin
      id = 32'(i);
    end
  end
  return id;
endfunction

// LSR: data ready while RBR is full, THRE while no byte waits to go out
function automatic logic [7:0] ref_lsr(input logic rx_full, input logic tx_busy);
  logic [7:0] value;
  value = 8'h00;
  value[periph_pkg::lsr_dr]   = rx_full;
  value[periph_pkg::lsr_thre] = ~tx_busy;
  return value;
endfunction

// ========================================
// Compare tasks
// ========================================

task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                          input string what);
  if (got !== exp) begin
    $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first mismatch");
  end
endtask

// One-bit levels such as interrupts and handshake flags
task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first mismatch");
  end
endtask

// Region as the bus controller reads it through the dec view
task automatic check_region(input soc_map_pkg::soc_addr_u addr, input logic [7:0] exp,
                            input string what);
  if (addr.dec.region !== exp) begin
    $display("FAILED at %0t: %s, region %h, expected %h", $time, what,
             addr.dec.region, exp);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first mismatch");
  end
endtask

`default_nettype wire
`endif

/* tests/tb_rv_periph_soc.sv */
// Testbench for the peripheral platform
// Clock, reset, Wishbone master tasks and the TX hold monitor
// Memory, unmapped region, CLINT, UART and PLIC behaviors
`include "tb_model.svh"
`default_nettype none

module tb_rv_periph_soc;
  import soc_map_pkg::*;
  import periph_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;
  logic        err;
  logic        tx_valid;
  logic [7:0]  tx_data;
  logic        tx_ready;
  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        rx_ready;
  logic [1:0]  ext_irq;
  logic        msip;
  logic        mtip;
  logic        meip;

  // Response flags of the last access
  logic        resp_ack;
  logic        resp_err;
  // Data memory model, indexed by word
  logic [31:0] model_mem [dmem_words];
  // TX byte seen waiting at the previous edge
  logic        tx_held = 1'b0;
  logic [7:0]  tx_held_data = 8'h00;

  rv_periph_soc rv_periph_soc_inst (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .err(err),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
    .ext_irq(ext_irq), .msip(msip), .mtip(mtip), .meip(meip)
  );

  always #20 clk = ~clk;

  // ========================================
  // Bus master
  // ========================================
  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("** FAIL **");
    $fatal(1, "Timed out waiting on the DUT");
  endtask

  // Request held from a falling edge until ack or err is seen
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] lanes,
                            output logic [31:0] rdata);
    int waited;
    waited   = 0;
    cyc      = 1'b1;
    stb      = 1'b1;
    we       = write;
    adr      = addr;
    dat_w    = wdata;
    sel      = lanes;
    resp_ack = 1'b0;
    resp_err = 1'b0;
    while (!resp_ack && !resp_err) begin
      if (waited == 20) begin
        timeout_fail($sformatf("bus did not respond to address %h", addr));
      end
      @(negedge clk);
      waited++;
      resp_ack = ack;
      resp_err = err;
    end
    rdata = dat_r;
    check_word(32'(waited), 32'd1, "bus response latency in cycles");
    // Request stays up through the rising edge that samples the response
    @(negedge clk);
    // Drop the request, next access one cycle later
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
  endtask

  task automatic wb_write(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] lanes);
    logic [31:0] ignored;
    bus_access(1'b1, addr, wdata, lanes, ignored);
    check_bit(resp_ack, 1'b1, "ack on write");
    check_bit(resp_err, 1'b0, "err on write");
  endtask

  task automatic wb_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, 4'hf, rdata);
    check_bit(resp_ack, 1'b1, "ack on read");
    check_bit(resp_err, 1'b0, "err on read");
  endtask

  // Low half first, the high half cannot roll over in this run
  task automatic read_mtime(output logic [63:0] value);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read({region_clint, clint_mtime_lo}, lo);
    wb_read({region_clint, clint_mtime_hi}, hi);
    value = {hi, lo};
  endtask

  task automatic wait_meip(input string what);
    int waited;
    waited = 0;
    while (meip !== 1'b1) begin
      if (waited == 20) begin
        timeout_fail(what);
      end
      @(negedge clk);
      waited++;
    end
  endtask

  // Receive one byte, then serve its interrupt through the PLIC
  task automatic serve_rx_byte(input logic [7:0] rx_byte, input logic [3:0] plic_en);
    logic [31:0] rd;
    logic [31:0] claim_id;
    int          waited;
    waited   = 0;
    rx_data  = rx_byte;
    rx_valid = 1'b1;
    // Taken on the edge where rx_valid meets rx_ready
    do begin
      if (waited == 20) begin
        timeout_fail("receive holding register never took the byte");
      end
      @(negedge clk);
      waited++;
    end while (rx_ready);
    rx_valid = 1'b0;
    wait_meip("meip did not rise for the received byte");
    wb_read({region_uart, uart_lsr}, rd);
    check_word(rd, {24'b0, ref_lsr(1'b1, 1'b0)}, "LSR with a byte waiting");
    wb_read({region_plic, plic_claim}, claim_id);
    check_word(claim_id, ref_claim(4'(1 << irq_src_uart), plic_en), "claim of the UART");
    check_bit(meip, 1'b0, "meip after the claim");
    wb_read({region_uart, uart_rbr_thr}, rd);
    check_word(rd, {24'b0, rx_byte}, "RBR read");
    // Empty RBR takes the next byte again
    check_bit(rx_ready, 1'b1, "rx_ready once the RBR is read");
    wb_write({region_plic, plic_claim}, claim_id, 4'hf);
  endtask

  function automatic soc_addr_u dmem_addr(input logic [9:0] index);
    soc_addr_u a;
    a.mem.upper = {region_dmem, 12'h000};
    a.mem.index = index;
    a.mem.lane  = 2'b00;
    return a;
  endfunction

  // TX hold monitor, reads values from before the edge
  always @(posedge clk) begin
    if (tx_held) begin
      check_bit(tx_valid, 1'b1, "tx_valid dropped before tx_ready");
      check_word({24'b0, tx_data}, {24'b0, tx_held_data}, "tx_data while stalled");
    end
    tx_held      = !rst && tx_valid && !tx_ready;
    tx_held_data = tx_data;
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    soc_addr_u   a;
    logic [9:0]  mem_idx [10];
    logic [31:0] rd;
    logic [31:0] wdata;
    logic [3:0]  lanes;
    logic [63:0] now;
    logic [63:0] cmp;
    logic [7:0]  tx_byte;
    logic [3:0]  plic_en;
    logic [3:0]  pend_model;
    logic [31:0] exp_id;
    int          base;
    int          k;
    int          pick;
    int          hold;
    int          waited;
    rst      = 1'b1;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = 32'h0;
    dat_w    = 32'h0;
    sel      = 4'h0;
    tx_ready = 1'b0;
    rx_valid = 1'b0;
    rx_data  = 8'h00;
    ext_irq  = 2'b00;
    void'($urandom(32'hf4d1));
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Ten distinct words, each given a known value first
    base = int'($urandom_range(0, dmem_words - 1));
    for (k = 0; k < 10; k++) begin
      mem_idx[k] = 10'((base + k * 101) % dmem_words);
      wdata = $urandom;
      wb_write(dmem_addr(mem_idx[k]), wdata, 4'hf);
      model_mem[mem_idx[k]] = wdata;
    end
    // 40 partial writes with random lanes
    for (k = 0; k < 40; k++) begin
      pick  = int'($urandom_range(0, 9));
      wdata = $urandom;
      lanes = 4'($urandom);
      wb_write(dmem_addr(mem_idx[pick]), wdata, lanes);
      model_mem[mem_idx[pick]] = lane_merge(model_mem[mem_idx[pick]], wdata, lanes);
    end
    for (k = 0; k < 10; k++) begin
      a = dmem_addr(mem_idx[k]);
      check_region(a, region_dmem, "decoded region of a data memory address");
      wb_read(a, rd);
      check_word(rd, model_mem[mem_idx[k]], "data memory read");
    end

    // Unmapped region with the word index of a written word
    a = dmem_addr(mem_idx[0]);
    a.dec.region = 8'h40;
    bus_access(1'b1, a, ~model_mem[mem_idx[0]], 4'hf, rd);
    check_bit(resp_err, 1'b1, "err on the unmapped region");
    check_bit(resp_ack, 1'b0, "ack on the unmapped region");
    wb_read(dmem_addr(mem_idx[0]), rd);
    check_word(rd, model_mem[mem_idx[0]], "data memory after the unmapped write");

    // Software interrupt
    wb_write({region_clint, clint_msip}, 32'd1, 4'hf);
    check_bit(msip, 1'b1, "msip after writing 1");
    wb_write({region_clint, clint_msip}, 32'd0, 4'hf);
    check_bit(msip, 1'b0, "msip after writing 0");

    // Timer compare 60 ticks ahead
    read_mtime(now);
    cmp = now + 64'd60;
    wb_write({region_clint, clint_mtimecmp_lo}, cmp[31:0], 4'hf);
    wb_write({region_clint, clint_mtimecmp_hi}, cmp[63:32], 4'hf);
    check_bit(mtip, 1'b0, "mtip before mtime reaches mtimecmp");
    waited = 0;
    while (!mtip) begin
      if (waited == 200) begin
        timeout_fail("mtip never rose after mtimecmp was written");
      end
      @(negedge clk);
      waited++;
    end
    read_mtime(now);
    check_bit(now >= cmp, 1'b1, "mtime at least mtimecmp once mtip is high");

    // UART transmit with a stalled sink
    wb_read({region_uart, uart_lsr}, rd);
    check_word(rd, {24'b0, ref_lsr(1'b0, 1'b0)}, "LSR while idle");
    tx_byte = 8'($urandom);
    wb_write({region_uart, uart_rbr_thr}, {24'b0, tx_byte}, 4'h1);
    check_bit(tx_valid, 1'b1, "tx_valid after THR write");
    check_word({24'b0, tx_data}, {24'b0, tx_byte}, "tx_data after THR write");
    wb_read({region_uart, uart_lsr}, rd);
    check_word(rd, {24'b0, ref_lsr(1'b0, 1'b1)}, "LSR while the byte waits");
    hold = 2 + int'($urandom_range(0, 9));
    repeat (hold) @(negedge clk);
    tx_ready = 1'b1;
    waited   = 0;
    while (tx_valid) begin
      if (waited == 20) begin
        timeout_fail("tx_valid stayed high with tx_ready high");
      end
      @(negedge clk);
      waited++;
    end
    tx_ready = 1'b0;
    wb_read({region_uart, uart_lsr}, rd);
    check_word(rd, {24'b0, ref_lsr(1'b0, 1'b0)}, "LSR after the handoff");

    // UART receive interrupt, twice to see the completion reopen the source
    plic_en = 4'(1 << irq_src_uart);
    wb_write({region_uart, uart_ier}, 32'(1 << ier_rx), 4'hf);
    wb_write({region_plic, plic_enable}, {28'b0, plic_en}, 4'hf);
    serve_rx_byte(8'($urandom), plic_en);
    serve_rx_byte(8'($urandom), plic_en);

    // Both external sources pulse together
    plic_en = 4'((1 << irq_src_uart) | (1 << irq_src_ext0) | (1 << irq_src_ext1));
    wb_write({region_plic, plic_enable}, {28'b0, plic_en}, 4'hf);
    ext_irq = 2'b11;
    @(negedge clk);
    ext_irq = 2'b00;
    wait_meip("meip did not rise for the external sources");
    pend_model = 4'((1 << irq_src_ext0) | (1 << irq_src_ext1));
    wb_read({region_plic, plic_pending}, rd);
    check_word(rd, {28'b0, pend_model}, "pending after the external pulses");
    // Lowest ID first, then nothing left
    for (k = 0; k < 3; k++) begin
      exp_id = ref_claim(pend_model, plic_en);
      wb_read({region_plic, plic_claim}, rd);
      check_word(rd, exp_id, "claim order");
      pend_model[exp_id[1:0]] = 1'b0;
    end
    wb_write({region_plic, plic_claim}, 32'(irq_src_ext0), 4'hf);
    wb_write({region_plic, plic_claim}, 32'(irq_src_ext1), 4'hf);
    check_bit(meip, 1'b0, "meip after all sources were served");

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* uart/uart_regs.sv */
// UART register block, 16550 subset
// THR and RBR holding registers, IER, LSR
// Byte-wide valid/ready serial side and level interrupt
`default_nettype none

module uart_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [23:0] offset,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  output logic        tx_valid,
  output logic [7:0]  tx_data,
  input  logic        tx_ready,
  input  logic        rx_valid,
  input  logic [7:0]  rx_data,
  output logic        rx_ready,
  output logic        irq
);
  import periph_pkg::*;

  logic       access;
  logic       thr_write;
  logic       ier_write;
  logic       rbr_read;
  logic       rx_take;
  logic [7:0] rbr;
  logic       rbr_full;
  logic [1:0] ier;
  logic [7:0] lsr;

  assign access    = stb & ~ack;
  // THR only takes a byte while empty
  assign thr_write = access & we & (offset == uart_rbr_thr) & ~tx_valid;
  assign ier_write = access & we & (offset == uart_ier);
  assign rbr_read  = access & ~we & (offset == uart_rbr_thr);
  assign rx_ready  = ~rbr_full;
  assign rx_take   = rx_valid & rx_ready;

  // Line status
  always_comb begin
    lsr           = 8'h00;
    lsr[lsr_dr]   = rbr_full;
    lsr[lsr_thre] = ~tx_valid;
  end

  assign irq = (ier[ier_rx] & rbr_full) | (ier[ier_tx] & ~tx_valid);

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      tx_valid <= 1'b0;
      rbr_full <= 1'b0;
      ier      <= '0;
    end else begin
      ack <= access;
      if (tx_valid && tx_ready) begin
        tx_valid <= 1'b0;
      end
      if (thr_write) begin
        tx_valid <= 1'b1;
      end
      if (ier_write) begin
        ier[ier_rx] <= dat_w[ier_rx];
        ier[ier_tx] <= dat_w[ier_tx];
      end
      if (rbr_read) begin
        rbr_full <= 1'b0;
      end
      // Incoming byte wins over a read of an empty RBR
      if (rx_take) begin
        rbr_full <= 1'b1;
      end
    end
  end

  // Holding registers and read data
  always_ff @(posedge clk) begin
    if (thr_write) begin
      tx_data <= dat_w[7:0];
    end
    if (rx_take) begin
      rbr <= rx_data;
    end
    if (access && !we) begin
      case (offset)
        uart_rbr_thr: dat_r <= {24'b0, rbr};
        uart_ier:     dat_r <= {30'b0, ier};
        uart_lsr:     dat_r <= {24'b0, lsr};
        default:      dat_r <= '0;
      endcase
    end
  end

  a_tx_hold: assert property (@(posedge clk) disable iff (rst)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

`default_nettype wire
